// ==== rtl/core_pkg.sv ====
package core_pkg;

	// **************************************************
	// Widths and addresses
	// **************************************************

	localparam int XLEN = 64;
	localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;
	localparam int COMMIT_DELAY = 2; // Stages between write-back and the commit ports.

	// Major opcodes.
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_LUI
	} alu_op_e;

	// **************************************************
	// Bus structs
	// **************************************************

	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] addr;
	} ibus_req_t;

	typedef struct packed {
		logic        addr_ok;
		logic        data_ok;
		logic [31:0] data;
	} ibus_resp_t;

	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] wdata;
		logic [7:0]      strobe; // All ones for a store.
	} dbus_req_t;

	typedef struct packed {
		logic            addr_ok;
		logic            data_ok;
		logic [XLEN-1:0] data;
	} dbus_resp_t;

	typedef struct packed {
		alu_op_e         op;
		logic [4:0]      rs1;
		logic [4:0]      rs2;
		logic [4:0]      rd;
		logic [XLEN-1:0] imm;
		logic            use_imm;
		logic            is_load;
		logic            is_store;
		logic            is_branch;
		logic            branch_ne;
		logic            reg_write;
		logic            skip;
	} decoded_t;

endpackage

// ==== rtl/commit_if.sv ====
interface commit_if;
	import core_pkg::*;

	// One retired instruction.
	logic            valid;
	logic [XLEN-1:0] pc;
	logic [31:0]     instr;
	logic            wen;
	logic [4:0]      wdest;
	logic [XLEN-1:0] wdata;
	logic            skip;

	modport producer (
		output valid, pc, instr, wen, wdest, wdata, skip
	);

	modport consumer (
		input valid, pc, instr, wen, wdest, wdata, skip
	);

endinterface

// ==== rtl/fetch_unit.sv ====
module fetch_unit (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      redirect,
	input  logic [core_pkg::XLEN-1:0] next_pc,
	input  logic                      start,
	output core_pkg::ibus_req_t       ireq,
	input  core_pkg::ibus_resp_t      iresp,
	output logic [core_pkg::XLEN-1:0] pc,
	output logic [31:0]               instr,
	output logic                      instr_ok
);
	import core_pkg::*;

	logic busy; // Request outstanding.

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= RESET_PC;
		end else if (redirect) begin
			pc <= next_pc;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
		end else if (start) begin
			busy <= 1'b1;
		end else if (instr_ok) begin
			busy <= 1'b0;
		end
	end

	// Capture on the response beat.
	always_ff @(posedge clk) begin
		if (instr_ok) begin
			instr <= iresp.data;
		end
	end

	assign instr_ok = busy && iresp.data_ok;
	assign ireq = '{valid: busy, addr: pc};

	// The PC must not move under an open fetch.
	assert property (@(posedge clk) disable iff (!rst_n)
		ireq.valid && !iresp.data_ok |=> $stable(ireq.addr));

endmodule

// ==== rtl/decoder.sv ====
module decoder (
	input  logic [31:0]        instr,
	output core_pkg::decoded_t dec
);
	import core_pkg::*;

	logic [6:0]      opcode;
	logic [6:0]      funct7;
	logic [2:0]      funct3;
	logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	// Sign-extended immediates.
	assign imm_i = {{52{instr[31]}}, instr[31:20]};
	assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};

	always_comb begin
		dec = '0;
		dec.op = ALU_ADD;
		dec.rs1 = instr[19:15];
		dec.rs2 = instr[24:20];
		dec.rd = instr[11:7];
		dec.imm = imm_i;
		dec.skip = 1'b1; // Cleared below for supported encodings.
		case (opcode)
			OP_IMM: begin
				if (funct3 == 3'b000) begin // ADDI.
					dec.use_imm = 1'b1;
					dec.reg_write = 1'b1;
					dec.skip = 1'b0;
				end
			end
			OP_REG: begin
				dec.reg_write = 1'b1;
				dec.skip = 1'b0;
				case ({funct7, funct3})
					10'b0000000_000: dec.op = ALU_ADD;
					10'b0100000_000: dec.op = ALU_SUB;
					10'b0000000_100: dec.op = ALU_XOR;
					10'b0000000_110: dec.op = ALU_OR;
					10'b0000000_111: dec.op = ALU_AND;
					default: begin
						dec.reg_write = 1'b0;
						dec.skip = 1'b1;
					end
				endcase
			end
			OP_LUI: begin
				dec.op = ALU_LUI;
				dec.imm = imm_u;
				dec.reg_write = 1'b1;
				dec.skip = 1'b0;
			end
			OP_LOAD: begin
				if (funct3 == 3'b011) begin // LD.
					dec.use_imm = 1'b1;
					dec.is_load = 1'b1;
					dec.reg_write = 1'b1;
					dec.skip = 1'b0;
				end
			end
			OP_STORE: begin
				if (funct3 == 3'b011) begin // SD.
					dec.imm = imm_s;
					dec.use_imm = 1'b1;
					dec.is_store = 1'b1;
					dec.skip = 1'b0;
				end
			end
			OP_BRANCH: begin
				if (funct3[2:1] == 2'b00) begin // BEQ and BNE.
					dec.imm = imm_b;
					dec.is_branch = 1'b1;
					dec.branch_ne = funct3[0];
					dec.skip = 1'b0;
				end
			end
			default: ;
		endcase
	end

endmodule

// ==== rtl/regfile.sv ====
module regfile (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [4:0]                raddr1,
	input  logic [4:0]                raddr2,
	output logic [core_pkg::XLEN-1:0] rdata1,
	output logic [core_pkg::XLEN-1:0] rdata2,
	input  logic                      we,
	input  logic [4:0]                waddr,
	input  logic [core_pkg::XLEN-1:0] wdata
);
	import core_pkg::*;

	logic [XLEN-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != 5'd0) begin // x0 never written.
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = regs[raddr1];
	assign rdata2 = regs[raddr2];

endmodule

// ==== rtl/cpu.sv ====
module cpu (
	input  logic                 clk,
	input  logic                 rst_n,
	output core_pkg::ibus_req_t  ireq,
	input  core_pkg::ibus_resp_t iresp,
	output core_pkg::dbus_req_t  dreq,
	input  core_pkg::dbus_resp_t dresp,
	commit_if.producer           commit
);
	import core_pkg::*;

	typedef enum logic [1:0] {
		S_FETCH,
		S_EXEC,
		S_MEM,
		S_WB
	} state_e;

	state_e          state;
	logic            booted;
	logic            fetch_start;
	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] next_pc_q;
	logic [31:0]     instr;
	logic            instr_ok;
	decoded_t        dec;
	logic [XLEN-1:0] rs1_data, rs2_data;
	logic [XLEN-1:0] op_b, alu_res;
	logic            taken;
	logic [XLEN-1:0] result_q; // Also the data address until load data lands.
	logic [XLEN-1:0] store_q;

	// Next fetch leaves with write-back, the very first one right out of reset.
	assign fetch_start = (state == S_WB) || !booted;

	fetch_unit fetch_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.redirect (state == S_WB),
		.next_pc  (next_pc_q),
		.start    (fetch_start),
		.ireq     (ireq),
		.iresp    (iresp),
		.pc       (pc),
		.instr    (instr),
		.instr_ok (instr_ok)
	);

	decoder decoder_i (
		.instr (instr),
		.dec   (dec)
	);

	regfile regfile_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.raddr1 (dec.rs1),
		.raddr2 (dec.rs2),
		.rdata1 (rs1_data),
		.rdata2 (rs2_data),
		.we     (state == S_WB && dec.reg_write),
		.waddr  (dec.rd),
		.wdata  (result_q)
	);

	// **************************************************
	// Sequencer
	// **************************************************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= S_FETCH;
			booted <= 1'b0;
		end else begin
			booted <= 1'b1;
			case (state)
				S_FETCH: if (instr_ok) state <= S_EXEC;
				S_EXEC:  state <= (dec.is_load || dec.is_store) ? S_MEM : S_WB;
				S_MEM:   if (dresp.data_ok) state <= S_WB;
				default: state <= S_FETCH;
			endcase
		end
	end

	// **************************************************
	// ALU and branch
	// **************************************************

	assign op_b = dec.use_imm ? dec.imm : rs2_data;

	always_comb begin
		case (dec.op)
			ALU_SUB: alu_res = rs1_data - op_b;
			ALU_AND: alu_res = rs1_data & op_b;
			ALU_OR:  alu_res = rs1_data | op_b;
			ALU_XOR: alu_res = rs1_data ^ op_b;
			ALU_LUI: alu_res = dec.imm;
			default: alu_res = rs1_data + op_b;
		endcase
	end

	assign taken = dec.is_branch && ((rs1_data == rs2_data) != dec.branch_ne);

	always_ff @(posedge clk) begin
		if (state == S_EXEC) begin
			result_q <= alu_res;
			store_q <= rs2_data;
			next_pc_q <= taken ? pc + dec.imm : pc + 64'd4;
		end else if (state == S_MEM && dresp.data_ok && dec.is_load) begin
			result_q <= dresp.data;
		end
	end

	assign dreq = '{
		valid:  state == S_MEM,
		addr:   result_q,
		wdata:  store_q,
		strobe: dec.is_store ? 8'hff : 8'h00
	};

	// Retirement record.
	assign commit.valid = state == S_WB;
	assign commit.pc = pc;
	assign commit.instr = instr;
	assign commit.wen = dec.reg_write && dec.rd != 5'd0;
	assign commit.wdest = dec.rd;
	assign commit.wdata = result_q;
	assign commit.skip = dec.skip;

	// Only memory instructions reach the data bus.
	assert property (@(posedge clk) disable iff (!rst_n)
		dreq.valid |-> dec.is_load || dec.is_store);

	// Each retirement is followed at once by the next fetch.
	assert property (@(posedge clk) disable iff (!rst_n)
		commit.valid |=> ireq.valid);

endmodule

// ==== rtl/core.sv ====
module core (
	input  logic                      clk,
	input  logic                      rst_n,
	output core_pkg::ibus_req_t       ireq,
	input  core_pkg::ibus_resp_t      iresp,
	output core_pkg::dbus_req_t       dreq,
	input  core_pkg::dbus_resp_t      dresp,
	output logic                      commit_valid,
	output logic [core_pkg::XLEN-1:0] commit_pc,
	output logic [31:0]               commit_instr,
	output logic                      commit_wen,
	output logic [4:0]                commit_wdest,
	output logic [core_pkg::XLEN-1:0] commit_wdata,
	output logic                      commit_skip
);
	import core_pkg::*;

	commit_if commit_bus ();

	cpu cpu_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.ireq   (ireq),
		.iresp  (iresp),
		.dreq   (dreq),
		.dresp  (dresp),
		.commit (commit_bus.producer)
	);

	// **************************************************
	// Commit delay line
	// **************************************************

	logic [COMMIT_DELAY-1:0] valid_q;
	logic [XLEN-1:0]         pc_q [COMMIT_DELAY];
	logic [31:0]             instr_q [COMMIT_DELAY];
	logic [COMMIT_DELAY-1:0] wen_q;
	logic [4:0]              wdest_q [COMMIT_DELAY];
	logic [XLEN-1:0]         wdata_q [COMMIT_DELAY];
	logic [COMMIT_DELAY-1:0] skip_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else begin
			valid_q <= {valid_q[COMMIT_DELAY-2:0], commit_bus.valid};
		end
	end

	always_ff @(posedge clk) begin
		pc_q[0] <= commit_bus.pc;
		instr_q[0] <= commit_bus.instr;
		wdest_q[0] <= commit_bus.wdest;
		wdata_q[0] <= commit_bus.wdata;
		wen_q <= {wen_q[COMMIT_DELAY-2:0], commit_bus.wen};
		skip_q <= {skip_q[COMMIT_DELAY-2:0], commit_bus.skip};
		for (int i = 1; i < COMMIT_DELAY; i++) begin
			pc_q[i] <= pc_q[i-1];
			instr_q[i] <= instr_q[i-1];
			wdest_q[i] <= wdest_q[i-1];
			wdata_q[i] <= wdata_q[i-1];
		end
	end

	assign commit_valid = valid_q[COMMIT_DELAY-1];
	assign commit_pc = pc_q[COMMIT_DELAY-1];
	assign commit_instr = instr_q[COMMIT_DELAY-1];
	assign commit_wen = wen_q[COMMIT_DELAY-1];
	assign commit_wdest = wdest_q[COMMIT_DELAY-1];
	assign commit_wdata = wdata_q[COMMIT_DELAY-1];
	assign commit_skip = skip_q[COMMIT_DELAY-1];

	// A retirement shows at the ports for one cycle only.
	assert property (@(posedge clk) disable iff (!rst_n)
		commit_valid |=> !commit_valid);

endmodule

// ==== dv/tb_clock.sv ====
module tb_clock (
	input  logic restart,
	output logic clk,
	output logic rst_n
);

	int unsigned hold = 8; // Reset cycles left.

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		if (restart) begin
			hold <= 8;
		end else if (hold != 0) begin
			hold <= hold - 1;
		end
	end

	assign rst_n = (hold == 0);

endmodule

// ==== dv/tb_mem.sv ====
module tb_mem (
	input  logic                  clk,
	input  logic                  rst_n,
	input  core_pkg::ibus_req_t   ireq,
	output core_pkg::ibus_resp_t  iresp,
	input  core_pkg::dbus_req_t   dreq,
	output core_pkg::dbus_resp_t  dresp
);
	import core_pkg::*;

	logic [31:0]     imem [256]; // Words from RESET_PC on.
	logic [XLEN-1:0] dmem [256]; // Doublewords from address zero on.
	int              i_wait;
	int              d_wait;

	initial begin
		iresp = '0;
		dresp = '0;
		i_wait = -1;
		d_wait = -1;
		void'($urandom(8196));
		forever begin
			@(posedge clk);
			if (!rst_n) begin
				iresp <= '0;
				dresp <= '0;
				i_wait = -1;
				d_wait = -1;
			end else begin
				// Instruction bus.
				if (iresp.data_ok) begin
					iresp <= '0;
				end else if (ireq.valid) begin
					if (i_wait < 0) i_wait = $urandom % 4;
					if (i_wait == 0) begin
						iresp <= '{addr_ok: 1'b1, data_ok: 1'b1, data: imem[ireq.addr[9:2]]};
						i_wait = -1;
					end else begin
						i_wait = i_wait - 1;
					end
				end
				// Data bus.
				if (dresp.data_ok) begin
					dresp <= '0;
				end else if (dreq.valid) begin
					if (d_wait < 0) d_wait = $urandom % 4;
					if (d_wait == 0) begin
						dresp <= '{addr_ok: 1'b1, data_ok: 1'b1, data: dmem[dreq.addr[10:3]]};
						if (dreq.strobe == 8'hff) dmem[dreq.addr[10:3]] = dreq.wdata;
						d_wait = -1;
					end else begin
						d_wait = d_wait - 1;
					end
				end
			end
		end
	end

endmodule

// ==== dv/core_tb.sv ====
module core_tb;
	import core_pkg::*;

	localparam int TOTAL_INSTR = 35;
	localparam int RESET_CYCLES = 5 * 12;
	localparam int CYCLE_LIMIT = TOTAL_INSTR * 12 + RESET_CYCLES + 100;

	logic            clk, rst_n, restart;
	ibus_req_t       ireq;
	ibus_resp_t      iresp;
	dbus_req_t       dreq;
	dbus_resp_t      dresp;
	logic            commit_valid, commit_wen, commit_skip;
	logic [XLEN-1:0] commit_pc, commit_wdata;
	logic [31:0]     commit_instr;
	logic [4:0]      commit_wdest;
	int              cycles = 0;

	// Reference model state.
	logic [31:0]     prog [$];
	logic [63:0]     m_regs [32];
	logic [63:0]     m_mem [logic [63:0]];
	logic [63:0]     m_pc;
	logic [63:0]     e_pc, e_wdata, e_saddr, e_sdata;
	logic [31:0]     e_instr;
	logic [4:0]      e_wdest;
	logic            e_wen, e_skip, e_store;

	tb_clock clock_i (.restart(restart), .clk(clk), .rst_n(rst_n));

	tb_mem mem_i (
		.clk(clk), .rst_n(rst_n), .ireq(ireq), .iresp(iresp), .dreq(dreq), .dresp(dresp)
	);

	core core_i (
		.clk(clk), .rst_n(rst_n), .ireq(ireq), .iresp(iresp), .dreq(dreq), .dresp(dresp),
		.commit_valid(commit_valid), .commit_pc(commit_pc), .commit_instr(commit_instr),
		.commit_wen(commit_wen), .commit_wdest(commit_wdest), .commit_wdata(commit_wdata),
		.commit_skip(commit_skip)
	);

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the core stopped retiring instructions.");
			$display("Testbench failed");
			$fatal(1);
		end
	end

	task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	function automatic logic [63:0] fill_word(input logic [63:0] addr);
		return {addr[31:0] ^ 32'h5a5a_a5a5, addr[31:0]};
	endfunction

	// **************************************************
	// Encoders
	// **************************************************

	function automatic logic [31:0] addi(input logic [4:0] rd, rs1, input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, 7'h13};
	endfunction

	function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [2:0] f3,
			input logic [4:0] rd, rs1, rs2);
		return {f7, rs2, rs1, f3, rd, 7'h33};
	endfunction

	function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] imm);
		return {imm, rd, 7'h37};
	endfunction

	function automatic logic [31:0] ld(input logic [4:0] rd, rs1, input logic [11:0] imm);
		return {imm, rs1, 3'b011, rd, 7'h03};
	endfunction

	function automatic logic [31:0] sd(input logic [4:0] rs2, rs1, input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] branch(input logic [2:0] f3, input logic [4:0] rs1, rs2,
			input logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
	endfunction

	// **************************************************
	// Reference model
	// **************************************************

	function automatic void model_step();
		logic [31:0] ins;
		logic [63:0] a, b, val, addr, npc, imm_i;
		logic [2:0]  f3;
		logic        wr;
		int          idx;
		idx = (m_pc - RESET_PC) >> 2;
		ins = (idx < prog.size()) ? prog[idx] : 32'h0;
		a = m_regs[ins[19:15]];
		b = m_regs[ins[24:20]];
		f3 = ins[14:12];
		imm_i = {{52{ins[31]}}, ins[31:20]};
		npc = m_pc + 4;
		wr = 1'b0;
		val = '0;
		e_skip = 1'b1;
		e_store = 1'b0;
		case (ins[6:0])
			7'h13: if (f3 == 3'b000) {val, wr, e_skip} = {a + imm_i, 2'b10};
			7'h33: begin
				{wr, e_skip} = 2'b10;
				case ({ins[31:25], f3})
					10'h000: val = a + b;
					10'h100: val = a - b;
					10'h004: val = a ^ b;
					10'h006: val = a | b;
					10'h007: val = a & b;
					default: {wr, e_skip} = 2'b01;
				endcase
			end
			7'h37: {val, wr, e_skip} = {{32{ins[31]}}, ins[31:12], 12'h000, 2'b10};
			7'h03: if (f3 == 3'b011) begin
				addr = a + imm_i;
				val = m_mem.exists(addr) ? m_mem[addr] : fill_word(addr);
				{wr, e_skip} = 2'b10;
			end
			7'h23: if (f3 == 3'b011) begin
				addr = a + {{52{ins[31]}}, ins[31:25], ins[11:7]};
				m_mem[addr] = b;
				{e_store, e_saddr, e_sdata, e_skip} = {1'b1, addr, b, 1'b0};
			end
			7'h63: if (f3[2:1] == 2'b00) begin
				e_skip = 1'b0;
				if ((a == b) != f3[0])
					npc = m_pc + {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
			end
			default: ;
		endcase
		e_pc = m_pc;
		e_instr = ins;
		e_wdest = ins[11:7];
		e_wdata = val;
		e_wen = wr && ins[11:7] != 5'd0;
		if (e_wen) m_regs[ins[11:7]] = val;
		m_pc = npc;
	endfunction

	// Resets the core, loads prog and checks n retirements.
	task automatic run_program(input int n);
		@(posedge clk);
		restart <= 1'b1;
		@(posedge clk);
		restart <= 1'b0;
		for (int i = 0; i < 256; i++) begin
			mem_i.imem[i] = (i < prog.size()) ? prog[i] : 32'h0;
			mem_i.dmem[i] = fill_word(i * 8);
		end
		foreach (m_regs[i]) m_regs[i] = '0;
		m_mem.delete();
		m_pc = RESET_PC;
		@(posedge clk);
		@(posedge clk); // First low edge only samples the reset.
		while (!rst_n) begin
			check_eq("commit_valid", commit_valid, 0);
			check_eq("ireq.valid", ireq.valid, 0);
			@(posedge clk);
		end
		while (!ireq.valid) @(posedge clk);
		check_eq("ireq.addr", ireq.addr, RESET_PC);
		for (int k = 0; k < n; k++) begin
			while (!commit_valid) @(posedge clk);
			model_step();
			check_eq("commit_pc", commit_pc, e_pc);
			check_eq("commit_instr", commit_instr, e_instr);
			check_eq("commit_wen", commit_wen, e_wen);
			check_eq("commit_skip", commit_skip, e_skip);
			if (e_wen) begin
				check_eq("commit_wdest", commit_wdest, e_wdest);
				check_eq("commit_wdata", commit_wdata, e_wdata);
			end
			if (e_store) check_eq("dmem", mem_i.dmem[e_saddr[10:3]], e_sdata);
			@(posedge clk);
		end
	endtask

	// **************************************************
	// Directed tests
	// **************************************************

	task automatic alu_test();
		prog = '{addi(1, 0, 12'h7ff), lui(2, 20'h80000), rtype(7'h00, 3'b000, 3, 1, 2),
			rtype(7'h20, 3'b000, 4, 0, 1), rtype(7'h00, 3'b111, 5, 3, 4),
			rtype(7'h00, 3'b110, 6, 1, 4), rtype(7'h00, 3'b100, 7, 3, 4),
			addi(8, 4, -12'sd1), lui(9, 20'h12345), rtype(7'h00, 3'b000, 10, 9, 9)};
		run_program(10);
	endtask

	task automatic zero_reg_test();
		prog = '{addi(0, 0, 12'd5), rtype(7'h00, 3'b000, 0, 1, 1), lui(0, 20'h1),
			addi(1, 0, 12'd3), rtype(7'h00, 3'b000, 2, 0, 1)};
		run_program(5);
	endtask

	task automatic mem_test();
		prog = '{addi(1, 0, 12'h100), lui(2, 20'hdeadb), addi(2, 2, -12'sh111),
			sd(2, 1, 12'd8), ld(3, 1, 12'd8), ld(4, 1, 12'd16), sd(3, 1, -12'sd8),
			ld(5, 1, -12'sd8)};
		run_program(8);
	endtask

	task automatic branch_test();
		prog = '{addi(1, 0, 12'd1), addi(2, 0, 12'd1), branch(3'b000, 1, 2, 13'd12),
			addi(3, 0, 12'd9), addi(3, 0, 12'd9), branch(3'b001, 1, 2, 13'd8),
			addi(4, 0, 12'd2), branch(3'b001, 4, 1, 13'd8), addi(5, 0, 12'd7),
			branch(3'b000, 0, 0, -13'sd36)};
		run_program(8); // Ends on the backward branch target.
	endtask

	task automatic skip_test();
		prog = '{32'hffff_ffff, addi(1, 0, 12'd4), rtype(7'h01, 3'b000, 3, 1, 1),
			addi(2, 1, 12'd1)};
		run_program(4);
	endtask

	initial begin
		restart = 1'b0;
		alu_test();
		zero_reg_test();
		mem_test();
		branch_test();
		skip_test();
		$display("Testbench passed");
		$finish;
	end

endmodule

// ==== all.f ====
rtl/core_pkg.sv
rtl/commit_if.sv
rtl/fetch_unit.sv
rtl/decoder.sv
rtl/regfile.sv
rtl/cpu.sv
rtl/core.sv
dv/tb_clock.sv
dv/tb_mem.sv
dv/core_tb.sv

// ==== Bender.yml ====
package:
  name: core

sources:
  - rtl/core_pkg.sv
  - rtl/commit_if.sv
  - rtl/fetch_unit.sv
  - rtl/decoder.sv
  - rtl/regfile.sv
  - rtl/cpu.sv
  - rtl/core.sv
  - target: test
    files:
      - dv/tb_clock.sv
      - dv/tb_mem.sv
      - dv/core_tb.sv
